/* logic/acc_core.sv */
//////////////////////////////
// Accumulator core, one command per four-phase req/ack handshake
// Instantiated as both the main and the shadow core
//////////////////////////////

module acc_core (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      cmd_req_i,
  input  core_pkg::cmd_t            cmd_i,

  output logic                      cmd_ack_o,
  output logic [core_pkg::AccW-1:0] acc_o,
  output logic                      err_o
);

  import core_pkg::*;

  logic              ack_q;
  logic              err_q;
  logic [AccW-1:0]   acc_q;
  logic [AccW-1:0]   acc_d;
  logic              exec;
  logic              illegal;
  logic [AccW-1:0]   imm_ext;
  logic [2*AccW-1:0] shl_wide;
  logic [2*AccW-1:0] shr_wide;
  logic [AccW-1:0]   shift_res;

  // New request seen while ack is low
  assign exec = cmd_req_i & ~ack_q;

  assign imm_ext = AccW'(cmd_i.arith.imm);

  //////////////////////////////
  // Shift unit
  //////////////////////////////

  // Doubled word gives both the logical shift and the rotation
  assign shl_wide = {acc_q, acc_q} << cmd_i.shift.shamt;
  assign shr_wide = {acc_q, acc_q} >> cmd_i.shift.shamt;

  always_comb begin
    if (!cmd_i.shift.dir) begin
      // Left
      if (cmd_i.shift.rot) begin
        shift_res = shl_wide[2*AccW-1:AccW];
      end else begin
        shift_res = shl_wide[AccW-1:0];
      end
    end else begin
      // Right
      if (cmd_i.shift.rot) begin
        shift_res = shr_wide[AccW-1:0];
      end else begin
        shift_res = shr_wide[2*AccW-1:AccW];
      end
    end
  end

  //////////////////////////////
  // Command decode
  //////////////////////////////

  always_comb begin
    acc_d   = acc_q;
    illegal = 1'b0;
    if (cmd_i.arith.fmt) begin
      acc_d = shift_res;
    end else begin
      unique case (cmd_i.arith.op)
        OpAdd:   acc_d = acc_q + imm_ext;
        OpSub:   acc_d = acc_q - imm_ext;
        OpAnd:   acc_d = acc_q & imm_ext;
        OpOr:    acc_d = acc_q | imm_ext;
        OpXor:   acc_d = acc_q ^ imm_ext;
        OpLoad:  acc_d = imm_ext;
        // Accumulator kept as is
        default: illegal = 1'b1;
      endcase
    end
  end

  // Handshake, accumulator and sticky error
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      acc_q <= '0;
      err_q <= 1'b0;
    end else if (exec) begin
      ack_q <= 1'b1;
      acc_q <= acc_d;
      if (illegal) begin
        err_q <= 1'b1;
      end
    end else if (!cmd_req_i && ack_q) begin
      ack_q <= 1'b0;
    end
  end

  assign cmd_ack_o = ack_q;
  assign acc_o     = acc_q;
  assign err_o     = err_q;

endmodule

/* logic/core_pkg.sv */
//////////////////////////////
// Widths and command encoding of the accumulator core
// Imported by the core and by the lockstep top level
//////////////////////////////

package core_pkg;

  // Datapath and command widths
  localparam int unsigned AccW   = 16;
  localparam int unsigned CmdW   = 16;
  localparam int unsigned ImmW   = 12;
  localparam int unsigned ShamtW = 4;

  // Arithmetic opcodes, codes 6 and 7 are illegal
  typedef enum logic [2:0] {
    OpAdd  = 3'd0,
    OpSub  = 3'd1,
    OpAnd  = 3'd2,
    OpOr   = 3'd3,
    OpXor  = 3'd4,
    OpLoad = 3'd5
  } arith_op_e;

  //////////////////////////////
  // Command word views
  //////////////////////////////

  // Format bit low selects this view
  typedef struct packed {
    logic            fmt;
    arith_op_e       op;
    logic [ImmW-1:0] imm;
  } cmd_arith_t;

  // Format bit high selects this view
  typedef struct packed {
    logic                        fmt;
    logic                        dir;
    logic                        rot;
    logic [CmdW-ShamtW-4:0]      rsvd;
    logic [ShamtW-1:0]           shamt;
  } cmd_shift_t;

  // One command word, two decodings
  typedef union packed {
    cmd_arith_t arith;
    cmd_shift_t shift;
  } cmd_t;

endpackage

/* logic/delay_line.sv */
//////////////////////////////
// Shift register that presents its input Depth cycles later
// Clears to zero on reset
//////////////////////////////

module delay_line #(
  parameter int unsigned Width = lockstep_pkg::InBundleW,
  parameter int unsigned Depth = lockstep_pkg::LockstepOffset
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  logic [Depth-1:0][Width-1:0] stage_q;

  // Stage 0 takes the input, the last stage drives the output
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

/* logic/lockstep_cmp.sv */
//////////////////////////////
// Compares registered shadow outputs against delayed main outputs
// Drives the major alert of the lockstep pair
//////////////////////////////

module lockstep_cmp (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  lockstep_pkg::mubi_t                 cmp_en_i,
  input  logic [lockstep_pkg::OutBundleW-1:0] main_dly_i,
  input  logic [lockstep_pkg::OutBundleW-1:0] shadow_i,

  output logic                                alert_major_o
);

  import lockstep_pkg::*;

  logic [OutBundleW-1:0] shadow_q;
  logic                  cmp_active;
  logic                  mismatch;

  // Shadow output register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_i;
    end
  end

  // Anything but the off code keeps checking
  assign cmp_active = (cmp_en_i != MubiOff);

  assign mismatch = (shadow_q != main_dly_i);

  // Not sticky, follows the divergence
  assign alert_major_o = cmp_active & mismatch;

endmodule

/* logic/lockstep_pkg.sv */
//////////////////////////////
// Lockstep timing constants, enable encoding and bundle widths
// Imported by the sequencer, the comparator and the top level
//////////////////////////////

package lockstep_pkg;

  import core_pkg::*;

  // Shadow core lag in cycles
  localparam int unsigned LockstepOffset = 2;

  // Extra cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  // Sequencer counter must hold LockstepOffset
  localparam int unsigned OffsetCntW = $clog2(LockstepOffset + 1);

  // Multi-bit enable
  typedef logic [3:0] mubi_t;

  localparam mubi_t MubiOn  = 4'b0101;
  localparam mubi_t MubiOff = 4'b1010;

  // Request plus command word
  localparam int unsigned InBundleW = 1 + CmdW;

  // Ack, accumulator and error flag
  localparam int unsigned OutBundleW = 1 + AccW + 1;

endpackage

/* logic/lockstep_top.sv */
//////////////////////////////
// Dual-core lockstep around the accumulator core
// Main core drives the outputs, shadow core is checked against it
//////////////////////////////

module lockstep_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      cmd_req_i,
  input  core_pkg::cmd_t            cmd_i,
  input  logic                      fault_inj_i,

  output logic                      cmd_ack_o,
  output logic [core_pkg::AccW-1:0] acc_o,
  output logic                      alert_minor_o,
  output logic                      alert_major_o
);

  import core_pkg::*;
  import lockstep_pkg::*;

  // Main core
  logic            main_ack;
  logic [AccW-1:0] main_acc;
  logic            main_err;

  // Shadow core
  logic            shadow_rst_n;
  logic            shadow_req;
  cmd_t            shadow_cmd;
  cmd_t            shadow_cmd_in;
  logic            shadow_ack;
  logic [AccW-1:0] shadow_acc;
  logic            shadow_err;

  // Bundles and compare enable
  logic [InBundleW-1:0]  in_bundle;
  logic [InBundleW-1:0]  in_bundle_dly;
  logic [OutBundleW-1:0] main_bundle;
  logic [OutBundleW-1:0] main_bundle_dly;
  logic [OutBundleW-1:0] shadow_bundle;
  mubi_t                 cmp_en;

  acc_core u_main_core (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_req_i (cmd_req_i),
    .cmd_i     (cmd_i),
    .cmd_ack_o (main_ack),
    .acc_o     (main_acc),
    .err_o     (main_err)
  );

  //////////////////////////////
  // Shadow input path
  //////////////////////////////

  // Fault injection flips bit 0 of the shadow command
  assign shadow_cmd_in = cmd_i ^ {{(CmdW-1){1'b0}}, fault_inj_i};
  assign in_bundle     = {cmd_req_i, shadow_cmd_in};

  delay_line #(
    .Width (InBundleW),
    .Depth (LockstepOffset)
  ) u_in_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (in_bundle),
    .data_o (in_bundle_dly)
  );

  assign {shadow_req, shadow_cmd} = in_bundle_dly;

  shadow_rst_seq u_rst_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  acc_core u_shadow_core (
    .clk_i     (clk_i),
    .rst_ni    (shadow_rst_n),
    .cmd_req_i (shadow_req),
    .cmd_i     (shadow_cmd),
    .cmd_ack_o (shadow_ack),
    .acc_o     (shadow_acc),
    .err_o     (shadow_err)
  );

  //////////////////////////////
  // Output compare
  //////////////////////////////

  assign main_bundle   = {main_ack, main_acc, main_err};
  assign shadow_bundle = {shadow_ack, shadow_acc, shadow_err};

  delay_line #(
    .Width (OutBundleW),
    .Depth (OutputsOffset)
  ) u_out_dly (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_bundle),
    .data_o (main_bundle_dly)
  );

  lockstep_cmp u_cmp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmp_en_i      (cmp_en),
    .main_dly_i    (main_bundle_dly),
    .shadow_i      (shadow_bundle),
    .alert_major_o (alert_major_o)
  );

  assign cmd_ack_o     = main_ack;
  assign acc_o         = main_acc;
  assign alert_minor_o = main_err;

endmodule

/* logic/shadow_rst_seq.sv */
//////////////////////////////
// Shadow reset release and compare enable after reset
// Release comes LockstepOffset cycles after rst_ni rises
//////////////////////////////

module shadow_rst_seq (
  input  logic                clk_i,
  input  logic                rst_ni,

  output logic                shadow_rst_no,
  output lockstep_pkg::mubi_t cmp_en_o
);

  import lockstep_pkg::*;

  logic [OffsetCntW-1:0] cnt_q;
  logic                  release_d;
  logic                  release_q;
  mubi_t                 cmp_en_q;

  // Saturating counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != OffsetCntW'(LockstepOffset)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // One register stage follows the count
  assign release_d = (cnt_q >= OffsetCntW'(LockstepOffset - 1));

  // Reset asserts at once, release is synchronous
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      release_q <= 1'b0;
      cmp_en_q  <= MubiOff;
    end else begin
      release_q <= release_d;
      cmp_en_q  <= release_q ? MubiOn : MubiOff;
    end
  end

  assign shadow_rst_no = release_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

/* tb.f */
logic/core_pkg.sv
logic/lockstep_pkg.sv
logic/delay_line.sv
logic/acc_core.sv
logic/shadow_rst_seq.sv
logic/lockstep_cmp.sv
logic/lockstep_top.sv
verification/tb_lockstep_top.sv

/* verification/tb_lockstep_top.sv */
//////////////////////////////
// Directed testbench for the lockstep accumulator pair
// Runs reset, arithmetic, shift, illegal opcode and fault injection tests
//////////////////////////////

module tb_lockstep_top;

  timeunit 1ns;
  timeprecision 100ps;

  import core_pkg::*;

  // About 100 commands of some 6 cycles each, five times over
  localparam int NumCmds       = 100;
  localparam int CmdCycles     = 6;
  localparam int TimeoutCycles = NumCmds * CmdCycles * 5;

  logic            clk_i;
  logic            rst_ni;
  logic            cmd_req_i;
  cmd_t            cmd_i;
  logic            fault_inj_i;
  logic            cmd_ack_o;
  logic [AccW-1:0] acc_o;
  logic            alert_minor_o;
  logic            alert_major_o;

  int          cycle_cnt;
  int          test_err;
  int          check_err;
  int          tests_run;
  int          tests_failed;
  bit          major_seen;
  logic [15:0] model_acc;
  bit          model_err;

  lockstep_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_req_i     (cmd_req_i),
    .cmd_i         (cmd_i),
    .fault_inj_i   (fault_inj_i),
    .cmd_ack_o     (cmd_ack_o),
    .acc_o         (acc_o),
    .alert_minor_o (alert_minor_o),
    .alert_major_o (alert_major_o)
  );

  always #50 clk_i = ~clk_i;

  // Major alert watch, written on the falling edge and read on the rising edge
  always @(negedge clk_i) begin
    if (alert_major_o !== 1'b0) begin
      major_seen = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Run stopped after %0d cycles without finishing", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [15:0] model_next(input logic [15:0] acc,
                                             input logic [15:0] word,
                                             output bit bad);
    logic [15:0] imm;
    logic [3:0]  sh;
    logic [15:0] res;
    imm = {4'h0, word[11:0]};
    sh  = word[3:0];
    res = acc;
    bad = 1'b0;
    if (word[15]) begin
      // Direction then rotate
      case (word[14:13])
        2'b00: res = acc << sh;
        2'b01: res = (acc << sh) | (acc >> (5'd16 - sh));
        2'b10: res = acc >> sh;
        default: res = (acc >> sh) | (acc << (5'd16 - sh));
      endcase
    end else begin
      case (word[14:12])
        3'd0: res = acc + imm;
        3'd1: res = acc - imm;
        3'd2: res = acc & imm;
        3'd3: res = acc | imm;
        3'd4: res = acc ^ imm;
        3'd5: res = imm;
        default: bad = 1'b1;
      endcase
    end
    return res;
  endfunction

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR %s", what);
      test_err++;
    end
  endtask

  // One four-phase transfer, acc_o captured while ack is high
  task automatic send_cmd(input logic [15:0] word, output logic [15:0] acc_seen);
    bit got;
    got = 1'b0;
    @(posedge clk_i);
    cmd_i     <= cmd_t'(word);
    cmd_req_i <= 1'b1;
    for (int n = 0; n < 20 && !got; n++) begin
      @(negedge clk_i);
      got = (cmd_ack_o === 1'b1);
    end
    check_true(got, "acknowledge did not rise within 20 cycles");
    acc_seen = acc_o;
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    got = 1'b0;
    for (int n = 0; n < 20 && !got; n++) begin
      @(negedge clk_i);
      got = (cmd_ack_o === 1'b0);
    end
    check_true(got, "acknowledge did not fall within 20 cycles");
  endtask

  task automatic run_cmd(input logic [15:0] word);
    logic [15:0] seen;
    bit          bad;
    send_cmd(word, seen);
    model_acc = model_next(model_acc, word, bad);
    model_err = model_err | bad;
    check_val("acc_o", seen, model_acc);
    check_val("alert_minor_o", alert_minor_o, model_err);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni    <= 1'b1;
    model_acc = '0;
    model_err = 1'b0;
  endtask

  task automatic idle_no_major(input int cycles, input string what);
    repeat (cycles) @(posedge clk_i);
    check_true(!major_seen, what);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_err == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, test_err);
      tests_failed++;
    end
    check_err += test_err;
    test_err  = 0;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    @(negedge clk_i);
    check_val("cmd_ack_o", cmd_ack_o, 0);
    check_val("acc_o", acc_o, 0);
    check_val("alert_minor_o", alert_minor_o, 0);
    check_val("alert_major_o", alert_major_o, 0);
    @(posedge clk_i);
    major_seen = 1'b0;
    idle_no_major(10, "major alert rose while idle after reset");
    end_test("reset state");
  endtask

  task automatic test_arith();
    logic [2:0]  op;
    logic [11:0] imm;
    @(posedge clk_i);
    major_seen = 1'b0;
    for (int i = 0; i < 40; i++) begin
      op  = 3'($urandom_range(0, 5));
      imm = 12'($urandom);
      run_cmd({1'b0, op, imm});
    end
    idle_no_major(6, "major alert rose during arithmetic commands");
    end_test("arithmetic commands");
  endtask

  task automatic test_shift();
    logic [1:0] mode;
    logic [8:0] rsvd;
    logic [3:0] sh;
    @(posedge clk_i);
    major_seen = 1'b0;
    for (int i = 0; i < 30; i++) begin
      mode = 2'($urandom);
      rsvd = (i == 0) ? 9'h1ff : 9'($urandom);
      sh   = 4'($urandom);
      run_cmd({1'b1, mode, rsvd, sh});
    end
    idle_no_major(6, "major alert rose during shift commands");
    end_test("shift and rotate commands");
  endtask

  task automatic test_illegal();
    @(posedge clk_i);
    major_seen = 1'b0;
    // Known value, then both illegal codes
    run_cmd({1'b0, 3'd5, 12'h3c7});
    run_cmd({1'b0, 3'd6, 12'h111});
    check_val("alert_minor_o", alert_minor_o, 1);
    run_cmd({1'b0, 3'd7, 12'h222});
    for (int i = 0; i < 5; i++) begin
      run_cmd({1'b0, 3'($urandom_range(0, 4)), 12'($urandom)});
      check_val("alert_minor_o", alert_minor_o, 1);
    end
    idle_no_major(6, "major alert rose although both cores saw the illegal opcode");
    end_test("illegal opcode");
  endtask

  task automatic test_fault();
    bit hit;
    hit = 1'b0;
    run_cmd({1'b0, 3'd5, 12'h000});
    @(posedge clk_i);
    fault_inj_i <= 1'b1;
    // Odd load value, the shadow core loads it minus one
    run_cmd({1'b0, 3'd5, 12'h0a5});
    @(posedge clk_i);
    fault_inj_i <= 1'b0;
    // Return comes about three cycles after ack, so this covers 10 cycles
    for (int n = 0; n < 7 && !hit; n++) begin
      @(negedge clk_i);
      hit = (alert_major_o === 1'b1);
    end
    check_true(hit, "major alert did not rise after the injected fault");
    apply_reset();
    @(negedge clk_i);
    check_val("alert_major_o", alert_major_o, 0);
    check_val("alert_minor_o", alert_minor_o, 0);
    @(posedge clk_i);
    major_seen = 1'b0;
    idle_no_major(10, "major alert rose after reset following the fault");
    end_test("fault injection");
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    cmd_req_i    = 1'b0;
    cmd_i        = '0;
    fault_inj_i  = 1'b0;
    cycle_cnt    = 0;
    test_err     = 0;
    check_err    = 0;
    tests_run    = 0;
    tests_failed = 0;
    major_seen   = 1'b0;
    model_acc    = '0;
    model_err    = 1'b0;
    void'($urandom(32'hc271));

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset();
    test_arith();
    test_shift();
    test_illegal();
    test_fault();

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, check_err);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
